/* project.f */
hw/nandCommandPkg.sv
hw/wishboneCommandPort.sv
hw/waySequencer.sv
hw/primitiveTimerArbiter.sv
hw/pollingEngineTop.sv
verification/pollingEngine_assertions.sv
verification/pollingEngineTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = pollingEngineTb
FILELIST = project.f
BUILD    = obj_dir
LOG      = simulation.log

.PHONY: test clean help

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

help:
	@echo "test   build with Verilator, run the simulation, check the log"
	@echo "clean  remove the build directory and the log"
	@echo "help   list these targets"

/* verification/pollingEngineTb.sv */
`timescale 1ns/1ps
`default_nettype none

module pollingEngineTb;
    import nandCommandPkg::*;

    localparam int NumberOfWays = 4;
    localparam int PollCycles   = 20;
    localparam int AckTimeout   = 200;
    localparam int PollLimit    = 400;

    logic             iSystemClock;
    logic             reset;
    wishboneRequestT  wishboneRequest;
    wishboneResponseT wishboneResponse;

    integer     seed;
    int         errorCount;
    int         totalErrors;
    int         cycleCount = 0;
    string      testName;
    logic [7:0] expectedCompleted;
    logic [7:0] expectedRejected;

    pollingEngineTop #(
        .NumberOfWays(NumberOfWays),
        .PollCycles  (PollCycles)
    ) pollingEngineTop_inst (
        .iSystemClock    (iSystemClock),
        .reset           (reset),
        .wishboneRequest (wishboneRequest),
        .wishboneResponse(wishboneResponse)
    );

    bind primitiveTimerArbiter pollingEngineAssertions #(
        .NumberOfWays(NumberOfWays)
    ) arbiterChecks (
        .iSystemClock(iSystemClock),
        .reset       (reset),
        .pmReady     (pmReady),
        .pmLastStep  (pmLastStep),
        .ack         (1'b0)
    );

    bind wishboneCommandPort pollingEngineAssertions #(
        .NumberOfWays(NumberOfWays)
    ) portChecks (
        .iSystemClock(iSystemClock),
        .reset       (reset),
        .pmReady     ({NumberOfWays{1'b0}}),
        .pmLastStep  ({NumberOfWays{1'b0}}),
        .ack         (ack)
    );

    always #5 iSystemClock = ~iSystemClock;

    always @(posedge iSystemClock) begin
        cycleCount <= cycleCount + 1;
    end

    function automatic logic [31:0] commandWord(input logic [5:0] opcode,
                                                input logic [4:0] target, input logic [2:0] way);
        return {5'd0, way, 3'd0, 5'd3, 3'd0, target, 2'd0, opcode};
    endfunction

    function automatic logic [2:0] randomWay();
        return 3'({$random(seed)} % NumberOfWays);
    endfunction

    function automatic logic [31:0] expectedStatus();
        return {8'd0, expectedRejected, expectedCompleted, 8'd0};
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("MISMATCH %s %s: expected %h, actual %h", testName, what, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkAtLeast(input string what, input int minimum, input int actual);
        assert (actual >= minimum) else begin
            $display("MISMATCH %s %s: expected at least %0d, actual %0d", testName, what,
                     minimum, actual);
            errorCount++;
        end
    endtask

    // One Wishbone classic cycle; stb is dropped on the edge that sees ack.
    task automatic busCycle(input logic write, input logic [31:0] data,
                            output logic [31:0] readBack);
        logic gotAck;
        int   waited;
        @(negedge iSystemClock);
        wishboneRequest.cyc = 1'b1;
        wishboneRequest.stb = 1'b1;
        wishboneRequest.we  = write;
        wishboneRequest.adr = 4'd0;
        wishboneRequest.dat = data;
        gotAck   = 1'b0;
        waited   = 0;
        readBack = '0;
        while (!gotAck && waited < AckTimeout) begin
            @(negedge iSystemClock);
            waited++;
            if (wishboneResponse.ack) begin
                gotAck   = 1'b1;
                readBack = wishboneResponse.dat;
            end
        end
        wishboneRequest = '0;
        if (!gotAck) begin
            $display("%s: no Wishbone ack within %0d cycles", testName, AckTimeout);
            errorCount++;
        end
    endtask

    task automatic writeCommand(input logic [31:0] data);
        logic [31:0] unused;
        busCycle(1'b1, data, unused);
    endtask

    task automatic readStatus(output logic [31:0] status);
        busCycle(1'b0, 32'd0, status);
    endtask

    task automatic waitIdle(output logic [31:0] status);
        int polls;
        polls = 0;
        readStatus(status);
        while (status[7:0] != 8'd0 && polls < PollLimit) begin
            readStatus(status);
            polls++;
        end
        if (status[7:0] != 8'd0) begin
            $display("%s: ways still busy after %0d status reads", testName, PollLimit);
            errorCount++;
        end
    endtask

    task automatic finishTest(input int startErrors);
        $display("%s: %0d errors", testName, errorCount - startErrors);
    endtask

    task automatic testResetStatus();
        logic [31:0] status;
        int          startErrors;
        testName    = "resetStatus";
        startErrors = errorCount;
        readStatus(status);
        checkValue("status", expectedStatus(), status);
        finishTest(startErrors);
    endtask

    task automatic testSingleWait();
        logic [31:0] status;
        logic [2:0]  way;
        int          startErrors;
        int          startCycle;
        testName    = "singleWait";
        startErrors = errorCount;
        way         = randomWay();
        writeCommand(commandWord(PowerOnWaitOpcode, PowerOnWaitTarget, way));
        startCycle = cycleCount;
        readStatus(status);
        checkValue("busy bits", 32'(8'd1 << way), 32'(status[7:0]));
        waitIdle(status);
        checkAtLeast("elapsed cycles", PollCycles, cycleCount - startCycle);
        expectedCompleted = expectedCompleted + 8'd1;
        checkValue("status", expectedStatus(), status);
        finishTest(startErrors);
    endtask

    task automatic testWrongCommand();
        logic [31:0] status;
        int          startErrors;
        testName    = "wrongCommand";
        startErrors = errorCount;
        writeCommand(commandWord(6'b000001, PowerOnWaitTarget, randomWay()));
        expectedRejected = expectedRejected + 8'd1;
        writeCommand(commandWord(PowerOnWaitOpcode, 5'b00110, randomWay()));
        expectedRejected = expectedRejected + 8'd1;
        readStatus(status);
        checkValue("status", expectedStatus(), status);
        finishTest(startErrors);
    endtask

    task automatic testWayOutOfRange();
        logic [31:0] status;
        int          startErrors;
        testName    = "wayOutOfRange";
        startErrors = errorCount;
        writeCommand(commandWord(PowerOnWaitOpcode, PowerOnWaitTarget,
                                 3'(NumberOfWays) + randomWay()));
        expectedRejected = expectedRejected + 8'd1;
        readStatus(status);
        checkValue("status", expectedStatus(), status);
        finishTest(startErrors);
    endtask

    task automatic testBackPressure();
        logic [31:0] status;
        logic [2:0]  way;
        int          startErrors;
        int          firstAccept;
        testName    = "backPressure";
        startErrors = errorCount;
        way         = randomWay();
        writeCommand(commandWord(PowerOnWaitOpcode, PowerOnWaitTarget, way));
        firstAccept = cycleCount;
        // Held off until the first wait on this way has finished.
        writeCommand(commandWord(PowerOnWaitOpcode, PowerOnWaitTarget, way));
        checkAtLeast("second accept delay", PollCycles, cycleCount - firstAccept);
        waitIdle(status);
        expectedCompleted = expectedCompleted + 8'd2;
        checkValue("status", expectedStatus(), status);
        finishTest(startErrors);
    endtask

    task automatic testAllWays();
        logic [31:0] status;
        int          startErrors;
        testName    = "allWays";
        startErrors = errorCount;
        for (int way = 0; way < NumberOfWays; way++) begin
            writeCommand(commandWord(PowerOnWaitOpcode, PowerOnWaitTarget, 3'(way)));
        end
        waitIdle(status);
        expectedCompleted = expectedCompleted + 8'(NumberOfWays);
        checkValue("status", expectedStatus(), status);
        finishTest(startErrors);
    endtask

    initial begin
        seed              = 29;
        errorCount        = 0;
        expectedCompleted = 8'd0;
        expectedRejected  = 8'd0;
        testName          = "reset";
        iSystemClock      = 1'b0;
        reset             = 1'b1;
        wishboneRequest   = '0;
        repeat (5) @(negedge iSystemClock);
        reset = 1'b0;

        testResetStatus();
        testSingleWait();
        testWrongCommand();
        testWayOutOfRange();
        testBackPressure();
        testAllWays();

        totalErrors = errorCount
                      + pollingEngineTop_inst.primitiveTimerArbiter_inst.arbiterChecks.failureCount
                      + pollingEngineTop_inst.wishboneCommandPort_inst.portChecks.failureCount;
        $display("Tests run: 6, errors: %0d", totalErrors);
        if (totalErrors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/pollingEngine_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module pollingEngineAssertions #(
    parameter int NumberOfWays = 4
) (
    input logic                    iSystemClock,
    input logic                    reset,
    input logic [NumberOfWays-1:0] pmReady,
    input logic [NumberOfWays-1:0] pmLastStep,
    input logic                    ack
);
    logic [NumberOfWays-1:0] granted;
    int                      failureCount = 0;

    // Ways that hold the timer, from grant until last step.
    always @(posedge iSystemClock) begin
        if (reset) begin
            granted <= '0;
        end else begin
            granted <= (granted | pmReady) & ~pmLastStep;
        end
    end

    // At most one grant, and only while no way holds the timer.
    grantOneHot: assert property (@(posedge iSystemClock) disable iff (reset)
        $onehot0(pmReady) && ((pmReady == '0) || (granted == '0)))
        else begin
            $error("pmReady is high for more than one way or while the timer is held");
            failureCount++;
        end

    ackOneCycle: assert property (@(posedge iSystemClock) disable iff (reset)
        ack |=> !ack)
        else begin
            $error("Wishbone ack stayed high for more than one cycle");
            failureCount++;
        end

    lastStepAfterGrant: assert property (@(posedge iSystemClock) disable iff (reset)
        (pmLastStep & ~granted) == '0)
        else begin
            $error("pmLastStep pulsed for a way that holds no grant");
            failureCount++;
        end

endmodule

`default_nettype wire

/* hw/pollingEngineTop.sv */
`timescale 1ns/1ps
`default_nettype none

module pollingEngineTop #(
    parameter int NumberOfWays = 4,
    parameter int PollCycles   = 11000
) (
    input  logic                             iSystemClock,
    input  logic                             reset,
    input  nandCommandPkg::wishboneRequestT  wishboneRequest,
    output nandCommandPkg::wishboneResponseT wishboneResponse
);
    import nandCommandPkg::*;

    logic [NumberOfWays-1:0] cmdValid;
    logic [NumberOfWays-1:0] cmdReady;
    logic [NumberOfWays-1:0] start;
    logic [NumberOfWays-1:0] lastStep;
    logic [NumberOfWays-1:0] pmReady;
    logic [NumberOfWays-1:0] pmLastStep;
    commandT                 command;
    primitiveRequestT        primitiveRequest [NumberOfWays];

    wishboneCommandPort #(
        .NumberOfWays(NumberOfWays)
    ) wishboneCommandPort_inst (
        .iSystemClock    (iSystemClock),
        .reset           (reset),
        .wishboneRequest (wishboneRequest),
        .wishboneResponse(wishboneResponse),
        .cmdValid        (cmdValid),
        .command         (command),
        .cmdReady        (cmdReady),
        .start           (start),
        .lastStep        (lastStep)
    );

    // One sequencer per way.
    for (genvar way = 0; way < NumberOfWays; way++) begin : gWay
        waySequencer #(
            .PollCycles(PollCycles)
        ) waySequencer_inst (
            .iSystemClock    (iSystemClock),
            .reset           (reset),
            .cmdValid        (cmdValid[way]),
            .command         (command),
            .cmdReady        (cmdReady[way]),
            .start           (start[way]),
            .lastStep        (lastStep[way]),
            .primitiveRequest(primitiveRequest[way]),
            .pmReady         (pmReady[way]),
            .pmLastStep      (pmLastStep[way])
        );
    end

    primitiveTimerArbiter #(
        .NumberOfWays(NumberOfWays)
    ) primitiveTimerArbiter_inst (
        .iSystemClock    (iSystemClock),
        .reset           (reset),
        .primitiveRequest(primitiveRequest),
        .pmReady         (pmReady),
        .pmLastStep      (pmLastStep)
    );

endmodule

`default_nettype wire

/* hw/primitiveTimerArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module primitiveTimerArbiter #(
    parameter int NumberOfWays = 4
) (
    input  logic                             iSystemClock,
    input  logic                             reset,
    input  nandCommandPkg::primitiveRequestT primitiveRequest [NumberOfWays],
    output logic [NumberOfWays-1:0]          pmReady,
    output logic [NumberOfWays-1:0]          pmLastStep
);
    import nandCommandPkg::*;

    localparam int IndexWidth = $clog2(NumberOfWays);

    logic [NumberOfWays-1:0] requestBits;
    logic                    timerBusy;
    logic [IndexWidth-1:0]   owner;
    logic [IndexWidth-1:0]   lastGrant;
    logic [IndexWidth-1:0]   grantIndex;
    logic                    grantValid;
    logic [15:0]             counter;
    logic                    timerDone;

    always_comb begin
        for (int way = 0; way < NumberOfWays; way++) begin
            requestBits[way] = primitiveRequest[way].pCommand[0];
        end
    end

    // Search starts one past the last granted way.
    always_comb begin
        int candidate;
        grantValid = 1'b0;
        grantIndex = '0;
        for (int offset = 1; offset <= NumberOfWays; offset++) begin
            candidate = (int'(lastGrant) + offset) % NumberOfWays;
            if (!grantValid && requestBits[candidate]) begin
                grantValid = 1'b1;
                grantIndex = IndexWidth'(candidate);
            end
        end
    end

    assign timerDone = timerBusy && (counter == 16'd0);

    always_comb begin
        for (int way = 0; way < NumberOfWays; way++) begin
            pmReady[way]    = !timerBusy && grantValid && (grantIndex == IndexWidth'(way));
            pmLastStep[way] = timerDone && (owner == IndexWidth'(way));
        end
    end

    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            timerBusy <= 1'b0;
            lastGrant <= IndexWidth'(NumberOfWays - 1);
        end else if (timerBusy) begin
            if (timerDone) begin
                timerBusy <= 1'b0;
            end
        end else if (grantValid) begin
            timerBusy <= 1'b1;
            lastGrant <= grantIndex;
        end
    end

    // Countdown of the running primitive.
    always_ff @(posedge iSystemClock) begin
        if (!timerBusy && grantValid) begin
            owner   <= grantIndex;
            counter <= primitiveRequest[grantIndex].numOfData;
        end else if (timerBusy && !timerDone) begin
            counter <= counter - 16'd1;
        end
    end

endmodule

`default_nettype wire

/* hw/waySequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module waySequencer #(
    parameter int PollCycles = 11000
) (
    input  logic                             iSystemClock,
    input  logic                             reset,
    input  logic                             cmdValid,
    input  nandCommandPkg::commandT          command,
    output logic                             cmdReady,
    output logic                             start,
    output logic                             lastStep,
    output nandCommandPkg::primitiveRequestT primitiveRequest,
    input  logic                             pmReady,
    input  logic                             pmLastStep
);
    import nandCommandPkg::*;

    typedef enum logic [1:0] {
        StateIdle  = 2'b00,
        StateIssue = 2'b01,
        StateWait  = 2'b11
    } stateT;

    stateT currentState;
    stateT nextState;
    logic  triggered;

    // Only the power-on wait is handled here.
    assign triggered = cmdValid && (command.opcode == PowerOnWaitOpcode)
                       && (command.targetId == PowerOnWaitTarget);

    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            currentState <= StateIdle;
        end else begin
            currentState <= nextState;
        end
    end

    always_comb begin
        case (currentState)
            StateIdle:  nextState = triggered ? StateIssue : StateIdle;
            StateIssue: nextState = pmReady ? StateWait : StateIssue;
            StateWait:  nextState = lastStep ? StateIdle : StateWait;
            default:    nextState = StateIdle;
        endcase
    end

    assign cmdReady = (currentState == StateIdle);
    assign start    = triggered;
    assign lastStep = (currentState == StateWait) && pmLastStep;

    assign primitiveRequest.pCommand       = {7'd0, currentState == StateIssue};
    assign primitiveRequest.pCommandOption = 3'b000;
    assign primitiveRequest.numOfData      = 16'(PollCycles);

endmodule

`default_nettype wire

/* hw/wishboneCommandPort.sv */
`timescale 1ns/1ps
`default_nettype none

module wishboneCommandPort #(
    parameter int NumberOfWays = 4
) (
    input  logic                             iSystemClock,
    input  logic                             reset,
    input  nandCommandPkg::wishboneRequestT  wishboneRequest,
    output nandCommandPkg::wishboneResponseT wishboneResponse,
    output logic [NumberOfWays-1:0]          cmdValid,
    output nandCommandPkg::commandT          command,
    input  logic [NumberOfWays-1:0]          cmdReady,
    input  logic [NumberOfWays-1:0]          start,
    input  logic [NumberOfWays-1:0]          lastStep
);
    import nandCommandPkg::*;

    logic        writePending;
    logic [2:0]  pendingWay;
    commandT     pendingCommand;
    logic        registeredAck;
    logic [31:0] readData;
    logic [7:0]  completedCount;
    logic [7:0]  rejectedCount;
    logic [7:0]  busyBits;
    logic [2:0]  requestWay;
    logic        newCycle;
    logic        handshake;
    logic        accepted;
    logic        ack;

    // A new bus cycle starts only once the previous one has fully ended.
    assign newCycle = wishboneRequest.cyc && wishboneRequest.stb && !writePending
                      && !registeredAck;
    assign requestWay = wishboneRequest.dat[26:24];

    always_comb begin
        for (int way = 0; way < NumberOfWays; way++) begin
            cmdValid[way] = writePending && (pendingWay == 3'(way));
        end
    end

    assign handshake = |(cmdValid & cmdReady);
    assign accepted  = |(cmdValid & start);
    assign command   = pendingCommand;

    always_comb begin
        busyBits = '0;
        busyBits[NumberOfWays-1:0] = ~cmdReady;
    end

    assign ack = registeredAck || handshake;
    assign wishboneResponse.ack = ack;
    assign wishboneResponse.dat = readData;

    always_ff @(posedge iSystemClock) begin
        if (reset) begin
            writePending   <= 1'b0;
            registeredAck  <= 1'b0;
            completedCount <= '0;
            rejectedCount  <= '0;
        end else begin
            registeredAck <= 1'b0;
            completedCount <= completedCount + 8'($countones(lastStep));

            if (newCycle) begin
                if (!wishboneRequest.we) begin
                    registeredAck <= 1'b1;
                end else if (wishboneRequest.adr != 4'd0) begin
                    registeredAck <= 1'b1;
                end else if (int'(requestWay) < NumberOfWays) begin
                    writePending <= 1'b1;
                end else begin
                    // Way out of range.
                    registeredAck <= 1'b1;
                    rejectedCount <= rejectedCount + 8'd1;
                end
            end

            if (handshake) begin
                writePending <= 1'b0;
                if (!accepted) begin
                    rejectedCount <= rejectedCount + 8'd1;
                end
            end
        end
    end

    // Captured command and read data.
    always_ff @(posedge iSystemClock) begin
        if (newCycle) begin
            pendingWay              <= requestWay;
            pendingCommand.opcode   <= wishboneRequest.dat[5:0];
            pendingCommand.targetId <= wishboneRequest.dat[12:8];
            pendingCommand.sourceId <= wishboneRequest.dat[20:16];
            if (!wishboneRequest.we && wishboneRequest.adr == 4'd0) begin
                readData <= {8'd0, rejectedCount, completedCount, busyBits};
            end else begin
                readData <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/nandCommandPkg.sv */
`default_nettype none

package nandCommandPkg;

    // Command as carried from the port to every way sequencer.
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] targetId;
        logic [4:0] sourceId;
    } commandT;

    // Primitive request toward the shared timer.
    // Bit 0 of pCommand triggers the timer.
    typedef struct packed {
        logic [7:0]  pCommand;
        logic [2:0]  pCommandOption;
        logic [15:0] numOfData;
    } primitiveRequestT;

    // Wishbone classic, master to slave.
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat;
    } wishboneRequestT;

    // Wishbone classic, slave to master.
    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wishboneResponseT;

    localparam logic [5:0] PowerOnWaitOpcode = 6'b111110;
    localparam logic [4:0] PowerOnWaitTarget = 5'b00101;

endpackage

`default_nettype wire
